// File: verilog/ptw_pkg.sv
/* paging constants and the address, entry, request and response types
   shared by the page-table walker miss queue */
`default_nettype none

package ptw_pkg;

	// ========================================
	// paging constants, 8 KiB pages with 8-byte entries
	// ========================================
	localparam int ADDR_W     = 32;
	localparam int PAGE_SHIFT = 13;
	localparam int PTE_SHIFT  = 3;
	localparam int IDX_W      = 10;

	// ========================================
	// basic types
	// ========================================
	typedef logic [ADDR_W-1:0] address_t;
	typedef logic [7:0] asid_t;
	typedef logic [5:0] rob_ndx_t;
	// ppn, table index and entry offset together fill a table address
	typedef logic [ADDR_W-IDX_W-PTE_SHIFT-1:0] ppn_t;
	typedef logic [2:0] level_t;

	// top table level and the done count of a finished walk
	localparam level_t     MAX_LEVEL  = 3'd1;
	localparam logic [1:0] DONE_COUNT = 2'd2;

	// root page number of the table plus the level the walk starts at
	typedef struct packed {
		logic [ADDR_W-PTE_SHIFT-1:0] adr;
		level_t level;
	} ptbr_t;

	// TLB miss as presented by the TLB
	typedef struct packed {
		asid_t asid;
		address_t adr;
		rob_ndx_t id;
	} miss_req_t;

	// one miss queue entry
	typedef struct packed {
		logic v;
		logic [1:0] bc;
		level_t lvl;
		asid_t asid;
		rob_ndx_t id;
		address_t adr;
		address_t tadr;
	} missq_entry_t;

	// page-table entry returned for a queue entry
	typedef struct packed {
		logic [3:0] qe;
		ppn_t ppn;
	} pte_rsp_t;

	// entry offered to the walker
	typedef struct packed {
		logic valid;
		logic [3:0] qe;
		level_t lvl;
		address_t tadr;
	} walk_req_t;

endpackage

`default_nettype wire

// File: verilog/miss_decode.sv
/* miss decode: duplicate check, lowest free entry search
   and the first table address of a new miss */
`timescale 1ns/1ps
`default_nettype none

module miss_decode #(
	parameter int MISSQ_SIZE = 8
) (
	input  logic miss,
	input  ptw_pkg::miss_req_t miss_req,
	input  ptw_pkg::ptbr_t ptbr,
	input  ptw_pkg::missq_entry_t [MISSQ_SIZE-1:0] entries,
	output logic dup_hit,
	output logic cap_en,
	output logic [3:0] cap_qe,
	output ptw_pkg::missq_entry_t cap_entry
);

	logic free_found;
	ptw_pkg::address_t root_adr;

	// already queued if any valid entry holds the same asid and address
	always_comb begin
		dup_hit = 1'b0;
		for (int i = 0; i < MISSQ_SIZE; i++) begin
			if (entries[i].v && entries[i].asid == miss_req.asid && entries[i].adr == miss_req.adr)
				dup_hit = 1'b1;
		end
	end

	// lowest free entry wins
	always_comb begin
		free_found = 1'b0;
		cap_qe = 4'd0;
		for (int i = 0; i < MISSQ_SIZE; i++) begin
			if (!entries[i].v && !free_found) begin
				free_found = 1'b1;
				cap_qe = 4'(i);
			end
		end
	end

	// a full queue drops the miss
	assign cap_en = miss && !dup_hit && free_found;

	assign root_adr = {ptbr.adr, {ptw_pkg::PTE_SHIFT{1'b0}}};

	always_comb begin
		cap_entry = '0;
		cap_entry.v = 1'b1;
		cap_entry.lvl = ptbr.level;
		cap_entry.asid = miss_req.asid;
		cap_entry.id = miss_req.id;
		cap_entry.adr = miss_req.adr;
		// index of the start level scaled to the 8-byte entry
		case (ptbr.level)
			3'd0: cap_entry.tadr = root_adr + ptw_pkg::address_t'({
				miss_req.adr[ptw_pkg::PAGE_SHIFT+ptw_pkg::IDX_W-1:ptw_pkg::PAGE_SHIFT],
				{ptw_pkg::PTE_SHIFT{1'b0}}});
			3'd1: cap_entry.tadr = root_adr + ptw_pkg::address_t'({
				miss_req.adr[ptw_pkg::ADDR_W-1:ptw_pkg::PAGE_SHIFT+ptw_pkg::IDX_W],
				{ptw_pkg::PTE_SHIFT{1'b0}}});
			default: cap_entry.tadr = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/walk_execute.sv
/* walker side of the miss queue: entry offered to the walker,
   level step decision and choice of a finished entry to free */
`timescale 1ns/1ps
`default_nettype none

module walk_execute #(
	parameter int MISSQ_SIZE = 8
) (
	input  logic walker_idle,
	input  logic walk_level,
	input  ptw_pkg::missq_entry_t [MISSQ_SIZE-1:0] entries,
	output ptw_pkg::walk_req_t walk_req,
	output logic step_en,
	output logic step_to_done,
	output logic free_en,
	output logic [3:0] free_qe
);

	logic sel_found;
	logic done_found;

	// ========================================
	// selection for the walker
	// ========================================
	// lowest valid entry that still has levels or done counts to go
	always_comb begin
		sel_found = 1'b0;
		walk_req = '0;
		for (int i = 0; i < MISSQ_SIZE; i++) begin
			if (!sel_found && entries[i].v && entries[i].bc < ptw_pkg::DONE_COUNT) begin
				sel_found = 1'b1;
				walk_req.valid = 1'b1;
				walk_req.qe = 4'(i);
				walk_req.lvl = entries[i].lvl;
				walk_req.tadr = entries[i].tadr;
			end
		end
	end

	// walk_level only counts while the walker sits idle
	assign step_en = walker_idle && walk_level && walk_req.valid;
	// at level 0 the done count moves instead of the level
	assign step_to_done = walk_req.lvl == 3'd0;

	// ========================================
	// retirement
	// ========================================
	always_comb begin
		done_found = 1'b0;
		free_qe = 4'd0;
		for (int i = 0; i < MISSQ_SIZE; i++) begin
			if (!done_found && entries[i].v && entries[i].bc == ptw_pkg::DONE_COUNT) begin
				done_found = 1'b1;
				free_qe = 4'(i);
			end
		end
	end

	assign free_en = walker_idle && done_found;

endmodule

`default_nettype wire

// File: verilog/pte_result.sv
/* page-table entry response: table index of the next level
   and the new table address of the addressed entry */
`timescale 1ns/1ps
`default_nettype none

module pte_result #(
	parameter int MISSQ_SIZE = 8
) (
	input  logic pte_valid,
	input  ptw_pkg::pte_rsp_t pte_rsp,
	input  ptw_pkg::missq_entry_t [MISSQ_SIZE-1:0] entries,
	output logic upd_en,
	output logic [3:0] upd_qe,
	output ptw_pkg::address_t upd_tadr
);

	ptw_pkg::missq_entry_t sel;
	logic [ptw_pkg::ADDR_W-ptw_pkg::PAGE_SHIFT-1:0] vpn;
	logic [ptw_pkg::ADDR_W-ptw_pkg::PAGE_SHIFT-1:0] pindex;

	// indices beyond the queue depth read as an invalid entry
	always_comb begin
		sel = '0;
		for (int i = 0; i < MISSQ_SIZE; i++) begin
			if (pte_rsp.qe == 4'(i))
				sel = entries[i];
		end
	end

	// virtual page number shifted down past the levels already resolved
	assign vpn = sel.adr[ptw_pkg::ADDR_W-1:ptw_pkg::PAGE_SHIFT];
	assign pindex = vpn >> (ptw_pkg::IDX_W * (sel.lvl + 3'd1));

	// level 0 entries that already counted once are finished
	assign upd_en = pte_valid && sel.v && !(sel.lvl == 3'd0 && sel.bc != 2'd0);
	assign upd_qe = pte_rsp.qe;
	assign upd_tadr = {pte_rsp.ppn, pindex[ptw_pkg::IDX_W-1:0], {ptw_pkg::PTE_SHIFT{1'b0}}};

endmodule

`default_nettype wire

// File: verilog/miss_queue_store.sv
/* miss queue entry registers with capture, step, free and update writes,
   plus the registered duplicate pulse */
`timescale 1ns/1ps
`default_nettype none

module miss_queue_store #(
	parameter int MISSQ_SIZE = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic miss,
	input  logic dup_hit,
	// capture
	input  logic cap_en,
	input  logic [3:0] cap_qe,
	input  ptw_pkg::missq_entry_t cap_entry,
	// step of the entry on walk_req
	input  ptw_pkg::walk_req_t walk_req,
	input  logic step_en,
	input  logic step_to_done,
	// free
	input  logic free_en,
	input  logic [3:0] free_qe,
	// table address update
	input  logic upd_en,
	input  logic [3:0] upd_qe,
	input  ptw_pkg::address_t upd_tadr,
	output ptw_pkg::missq_entry_t [MISSQ_SIZE-1:0] entries,
	output logic in_que
);

	// ========================================
	// duplicate pulse
	// ========================================
	// one cycle only, even for back to back duplicates
	always_ff @(posedge clk) begin
		if (rst)
			in_que <= 1'b0;
		else
			in_que <= miss && dup_hit && !in_que;
	end

	// ========================================
	// entry writes
	// ========================================
	// capture hits a free entry, step a live one, free a finished one,
	// and the update only touches tadr, so the writes never overlap
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MISSQ_SIZE; i++) begin
				entries[i].v <= 1'b0;
				entries[i].bc <= 2'd0;
			end
		end
		else begin
			for (int i = 0; i < MISSQ_SIZE; i++) begin
				if (cap_en && cap_qe == 4'(i))
					entries[i] <= cap_entry;

				if (step_en && walk_req.qe == 4'(i)) begin
					if (step_to_done)
						entries[i].bc <= entries[i].bc + 2'd1;
					else
						entries[i].lvl <= entries[i].lvl - 3'd1;
				end

				if (free_en && free_qe == 4'(i)) begin
					entries[i].v <= 1'b0;
					entries[i].bc <= 2'd0;
				end

				// uses the level before any step in this cycle
				if (upd_en && upd_qe == 4'(i))
					entries[i].tadr <= upd_tadr;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/ptw_miss_queue.sv
/* page-table walker miss queue top level */
`timescale 1ns/1ps
`default_nettype none

module ptw_miss_queue #(
	parameter int MISSQ_SIZE = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic miss,
	input  ptw_pkg::miss_req_t miss_req,
	input  ptw_pkg::ptbr_t ptbr,
	input  logic walker_idle,
	input  logic walk_level,
	input  logic pte_valid,
	input  ptw_pkg::pte_rsp_t pte_rsp,
	output logic in_que,
	output ptw_pkg::walk_req_t walk_req
);

	ptw_pkg::missq_entry_t [MISSQ_SIZE-1:0] entries;

	logic dup_hit;
	logic cap_en;
	logic [3:0] cap_qe;
	ptw_pkg::missq_entry_t cap_entry;

	logic step_en;
	logic step_to_done;
	logic free_en;
	logic [3:0] free_qe;

	logic upd_en;
	logic [3:0] upd_qe;
	ptw_pkg::address_t upd_tadr;

	miss_decode #(
		.MISSQ_SIZE(MISSQ_SIZE)
	) u_decode (
		.miss(miss),
		.miss_req(miss_req),
		.ptbr(ptbr),
		.entries(entries),
		.dup_hit(dup_hit),
		.cap_en(cap_en),
		.cap_qe(cap_qe),
		.cap_entry(cap_entry)
	);

	walk_execute #(
		.MISSQ_SIZE(MISSQ_SIZE)
	) u_execute (
		.walker_idle(walker_idle),
		.walk_level(walk_level),
		.entries(entries),
		.walk_req(walk_req),
		.step_en(step_en),
		.step_to_done(step_to_done),
		.free_en(free_en),
		.free_qe(free_qe)
	);

	pte_result #(
		.MISSQ_SIZE(MISSQ_SIZE)
	) u_result (
		.pte_valid(pte_valid),
		.pte_rsp(pte_rsp),
		.entries(entries),
		.upd_en(upd_en),
		.upd_qe(upd_qe),
		.upd_tadr(upd_tadr)
	);

	miss_queue_store #(
		.MISSQ_SIZE(MISSQ_SIZE)
	) u_store (
		.clk(clk),
		.rst(rst),
		.miss(miss),
		.dup_hit(dup_hit),
		.cap_en(cap_en),
		.cap_qe(cap_qe),
		.cap_entry(cap_entry),
		.walk_req(walk_req),
		.step_en(step_en),
		.step_to_done(step_to_done),
		.free_en(free_en),
		.free_qe(free_qe),
		.upd_en(upd_en),
		.upd_qe(upd_qe),
		.upd_tadr(upd_tadr),
		.entries(entries),
		.in_que(in_que)
	);

endmodule

`default_nettype wire

// File: tests/ptw_checker.sv
/* concurrent assertions on the miss queue outputs, bound to the top level */
`timescale 1ns/1ps
`default_nettype none

module ptw_checker (
	input logic clk,
	input logic rst,
	input logic in_que,
	input ptw_pkg::walk_req_t walk_req
);

	// duplicate pulse lasts a single cycle
	a_in_que_pulse: assert property (@(posedge clk) disable iff (rst) in_que |=> !in_que)
		else $error("in_que high two cycles running");

	a_walk_lvl: assert property (@(posedge clk) disable iff (rst)
		walk_req.lvl <= ptw_pkg::MAX_LEVEL)
		else $error("walk_req level above the top table level");

	// nothing offered right after reset
	a_reset_idle: assert property (@(posedge clk) rst |=> !walk_req.valid)
		else $error("walk_req valid after reset");

endmodule

bind ptw_miss_queue ptw_checker u_checker (
	.clk(clk),
	.rst(rst),
	.in_que(in_que),
	.walk_req(walk_req)
);

`default_nettype wire

// File: tests/tb_ptw_miss_queue.sv
/* miss queue testbench: stimulus, reference model of the queue
   and a per-cycle compare of walk_req and in_que */
`timescale 1ns/1ps
`default_nettype none

module tb_ptw_miss_queue;

	localparam int MISSQ_SIZE = 8;
	localparam int TIMEOUT = 64;

	logic clk;
	logic rst;
	logic miss;
	ptw_pkg::miss_req_t miss_req;
	ptw_pkg::ptbr_t ptbr;
	logic walker_idle;
	logic walk_level;
	logic pte_valid;
	ptw_pkg::pte_rsp_t pte_rsp;
	logic in_que;
	ptw_pkg::walk_req_t walk_req;

	ptw_pkg::missq_entry_t model_q [MISSQ_SIZE];
	logic model_in_que;
	integer seed;
	logic [28:0] root_pn;
	ptw_pkg::asid_t saved_asid [4];
	ptw_pkg::address_t saved_adr [4];
	ptw_pkg::walk_req_t first_req;

	ptw_miss_queue #(
		.MISSQ_SIZE(MISSQ_SIZE)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.miss(miss),
		.miss_req(miss_req),
		.ptbr(ptbr),
		.walker_idle(walker_idle),
		.walk_level(walk_level),
		.pte_valid(pte_valid),
		.pte_rsp(pte_rsp),
		.in_que(in_que),
		.walk_req(walk_req)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// ========================================
	// reference model
	// ========================================
	// root page plus the start-level index, in 8-byte entries
	function automatic ptw_pkg::address_t first_tadr(ptw_pkg::ptbr_t p, ptw_pkg::address_t va);
		ptw_pkg::address_t base;
		base = ptw_pkg::address_t'(p.adr) << 3;
		if (p.level == 3'd0)
			return base + (((va >> 13) & 32'h3ff) << 3);
		else if (p.level == 3'd1)
			return base + ((va >> 23) << 3);
		return '0;
	endfunction

	function automatic ptw_pkg::address_t next_tadr(ptw_pkg::missq_entry_t e, ptw_pkg::ppn_t ppn);
		logic [18:0] vpn;
		logic [18:0] idx;
		vpn = e.adr[31:13];
		idx = vpn >> (10 * (int'(e.lvl) + 1));
		return {ppn, idx[9:0], 3'b000};
	endfunction

	// scanning downward leaves the lowest live entry in w
	function automatic ptw_pkg::walk_req_t expected_walk_req();
		ptw_pkg::walk_req_t w;
		w = '0;
		for (int i = MISSQ_SIZE - 1; i >= 0; i--) begin
			if (model_q[i].v && model_q[i].bc < 2'd2) begin
				w.valid = 1'b1;
				w.qe = 4'(i);
				w.lvl = model_q[i].lvl;
				w.tadr = model_q[i].tadr;
			end
		end
		return w;
	endfunction

	function automatic int model_count();
		int n;
		n = 0;
		for (int i = 0; i < MISSQ_SIZE; i++)
			n += int'(model_q[i].v);
		return n;
	endfunction

	task automatic advance_model();
		ptw_pkg::missq_entry_t old_q [MISSQ_SIZE];
		ptw_pkg::walk_req_t sel;
		ptw_pkg::missq_entry_t e;
		logic dup;
		int free_slot;
		int done_slot;
		int k;
		old_q = model_q;
		sel = expected_walk_req();
		dup = 1'b0;
		free_slot = -1;
		done_slot = -1;
		for (int i = MISSQ_SIZE - 1; i >= 0; i--) begin
			if (old_q[i].v && old_q[i].asid == miss_req.asid && old_q[i].adr == miss_req.adr)
				dup = 1'b1;
			if (!old_q[i].v)
				free_slot = i;
			if (old_q[i].v && old_q[i].bc == 2'd2)
				done_slot = i;
		end
		model_in_que = miss && dup && !model_in_que;
		if (miss && !dup && free_slot >= 0) begin
			model_q[free_slot] = '0;
			model_q[free_slot].v = 1'b1;
			model_q[free_slot].lvl = ptbr.level;
			model_q[free_slot].asid = miss_req.asid;
			model_q[free_slot].id = miss_req.id;
			model_q[free_slot].adr = miss_req.adr;
			model_q[free_slot].tadr = first_tadr(ptbr, miss_req.adr);
		end
		k = int'(sel.qe);
		if (walker_idle && walk_level && sel.valid) begin
			if (old_q[k].lvl != 3'd0)
				model_q[k].lvl = old_q[k].lvl - 3'd1;
			else
				model_q[k].bc = old_q[k].bc + 2'd1;
		end
		if (walker_idle && done_slot >= 0) begin
			model_q[done_slot].v = 1'b0;
			model_q[done_slot].bc = 2'd0;
		end
		// level taken before the step of this cycle
		k = int'(pte_rsp.qe);
		if (pte_valid && k < MISSQ_SIZE) begin
			e = old_q[k];
			if (e.v && !(e.lvl == 3'd0 && e.bc >= 2'd1))
				model_q[k].tadr = next_tadr(e, pte_rsp.ppn);
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MISSQ_SIZE; i++)
				model_q[i] = '0;
			model_in_que = 1'b0;
		end
		else
			advance_model();
	end

	// ========================================
	// compare
	// ========================================
	task automatic check_walk_req(input ptw_pkg::walk_req_t got, input ptw_pkg::walk_req_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: walk_req valid=%b qe=%0d lvl=%0d tadr=%h", $time,
				got.valid, got.qe, got.lvl, got.tadr);
			$display("FAILED at %0t ns: expected valid=%b qe=%0d lvl=%0d tadr=%h", $time,
				exp.valid, exp.qe, exp.lvl, exp.tadr);
			$display("Testbench failed");
			$fatal(1, "walk_req mismatch");
		end
	endtask

	task automatic check_in_que(input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: in_que is %b, expected %b", $time, got, exp);
			$display("Testbench failed");
			$fatal(1, "in_que mismatch");
		end
	endtask

	always @(negedge clk) begin
		if (!rst) begin
			check_walk_req(walk_req, expected_walk_req());
			check_in_que(in_que, model_in_que);
		end
	end

	// ========================================
	// stimulus
	// ========================================
	task automatic send_miss(input ptw_pkg::asid_t asid, input ptw_pkg::address_t adr,
		input ptw_pkg::level_t lvl);
		ptw_pkg::miss_req_t r;
		ptw_pkg::ptbr_t p;
		r.asid = asid;
		r.adr = adr;
		r.id = ptw_pkg::rob_ndx_t'($random(seed));
		p.adr = root_pn;
		p.level = lvl;
		@(posedge clk);
		miss <= 1'b1;
		miss_req <= r;
		ptbr <= p;
		@(posedge clk);
		miss <= 1'b0;
	endtask

	task automatic send_pte(input int qe, input ptw_pkg::ppn_t ppn);
		@(posedge clk);
		pte_valid <= 1'b1;
		pte_rsp <= {4'(qe), ppn};
		@(posedge clk);
		pte_valid <= 1'b0;
	endtask

	task automatic step_walk();
		@(posedge clk);
		walk_level <= 1'b1;
		@(posedge clk);
		walk_level <= 1'b0;
	endtask

	// step every entry to the end, then wait until all are freed
	task automatic drain_queue();
		int guard;
		guard = 0;
		@(posedge clk);
		walker_idle <= 1'b1;
		@(negedge clk);
		while (walk_req.valid && guard < TIMEOUT) begin
			step_walk();
			@(negedge clk);
			guard++;
		end
		guard = 0;
		while (model_count() != 0 && guard < TIMEOUT) begin
			@(negedge clk);
			guard++;
		end
		if (walk_req.valid || model_count() != 0) begin
			$display("timeout: the queue did not drain");
			$display("Testbench failed");
			$fatal(1, "drain timeout");
		end
	endtask

	initial begin
		seed = 32'hd7a0_175b;
		rst = 1'b1;
		miss = 1'b0;
		miss_req = '0;
		ptbr = '0;
		walker_idle = 1'b0;
		walk_level = 1'b0;
		pte_valid = 1'b0;
		pte_rsp = '0;
		root_pn = 29'($random(seed));
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		@(negedge clk);
		check_walk_req(walk_req, '0);
		check_in_que(in_que, 1'b0);

		// capture at alternating start levels
		for (int i = 0; i < 4; i++) begin
			saved_asid[i] = ptw_pkg::asid_t'($random(seed));
			saved_adr[i] = ptw_pkg::address_t'($random(seed));
			send_miss(saved_asid[i], saved_adr[i], ptw_pkg::level_t'(i % 2));
		end
		first_req = '0;
		first_req.valid = 1'b1;
		first_req.tadr = first_tadr('{adr: root_pn, level: 3'd0}, saved_adr[0]);
		@(negedge clk);
		check_walk_req(walk_req, first_req);

		// duplicate miss only pulses in_que
		send_miss(saved_asid[2], saved_adr[2], 3'd0);
		@(negedge clk);
		check_in_que(in_que, 1'b1);
		@(negedge clk);
		check_in_que(in_que, 1'b0);

		// updates at level 1, at level 0, and past the queue depth
		send_pte(1, ptw_pkg::ppn_t'($random(seed)));
		send_pte(0, ptw_pkg::ppn_t'($random(seed)));
		send_pte(9, ptw_pkg::ppn_t'($random(seed)));

		@(posedge clk);
		walker_idle <= 1'b1;
		step_walk();
		send_pte(0, ptw_pkg::ppn_t'($random(seed)));
		step_walk();
		send_pte(1, ptw_pkg::ppn_t'($random(seed)));
		step_walk();
		send_pte(1, ptw_pkg::ppn_t'($random(seed)));
		drain_queue();

		// fill the queue, then one miss too many
		@(posedge clk);
		walker_idle <= 1'b0;
		for (int i = 0; i <= MISSQ_SIZE; i++)
			send_miss(ptw_pkg::asid_t'($random(seed)), ptw_pkg::address_t'($random(seed)), 3'd1);
		// a strobe while the walker is busy moves nothing
		step_walk();
		drain_queue();

		@(negedge clk);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
verilog/ptw_pkg.sv
verilog/miss_decode.sv
verilog/walk_execute.sv
verilog/pte_result.sv
verilog/miss_queue_store.sv
verilog/ptw_miss_queue.sv
tests/ptw_checker.sv
tests/tb_ptw_miss_queue.sv

// File: run.sh
#!/bin/sh
# build the miss queue testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_ptw_miss_queue &&
./obj_dir/Vtb_ptw_miss_queue | grep "^Testbench passed$" &&
echo "simulation ok" || { echo "simulation not ok"; exit 1; }
